//--- include/dual_issue_settings.svh
`ifndef DUAL_ISSUE_SETTINGS_SVH
`define DUAL_ISSUE_SETTINGS_SVH

// Instruction queue entries, a power of two.
`define QUEUE_DEPTH       16

// Primary opcodes.
`define OP_SPECIAL_INST   6'b000000
`define OP_REGIMM         6'b000001
`define OP_J              6'b000010
`define OP_JAL            6'b000011
`define OP_BEQ            6'b000100
`define OP_BNE            6'b000101
`define OP_ADDIU          6'b001001
`define OP_ORI            6'b001101
`define OP_LUI            6'b001111
`define OP_COP0           6'b010000
`define OP_LW             6'b100011
`define OP_SW             6'b101011

// Function codes of the SPECIAL group.
`define FN_JR             6'b001000
`define FN_SYSCALL        6'b001100
`define FN_MFHI           6'b010000
`define FN_MFLO           6'b010010
`define FN_MULT           6'b011000
`define FN_DIV            6'b011010

`endif

//--- verilog/issue_pkg.sv
`include "dual_issue_settings.svh"

package issue_pkg;

    // One instruction word.
    typedef logic [31:0] instr_t;

    // Primary opcode field.
    typedef logic [5:0] opcode_t;

    // General purpose register number.
    typedef logic [4:0] reg_addr_t;

    // Queue index and queue occupancy, the latter up to full.
    typedef logic [$clog2(`QUEUE_DEPTH)-1:0] q_ptr_t;
    typedef logic [$clog2(`QUEUE_DEPTH+1)-1:0] q_count_t;

    // Dual-issued pair counter.
    typedef logic [15:0] pair_count_t;

endpackage

//--- verilog/inst_queue.sv
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module inst_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_pair,
    input  issue_pkg::instr_t   in_instr0,
    input  issue_pkg::instr_t   in_instr1,
    input  logic [1:0]          pop_count,
    output issue_pkg::instr_t   head_instr,
    output issue_pkg::instr_t   next_instr,
    output logic                empty,
    output logic                almost_empty,
    output logic                in_ready
);

    issue_pkg::instr_t   mem [`QUEUE_DEPTH];
    issue_pkg::q_ptr_t   wr_ptr;
    issue_pkg::q_ptr_t   rd_ptr;
    issue_pkg::q_ptr_t   wr_ptr_plus1;
    issue_pkg::q_ptr_t   rd_ptr_plus1;
    issue_pkg::q_count_t count;
    issue_pkg::q_count_t push_num;
    logic                push;

    // Room for a full pair is required, even for a single push.
    assign in_ready = count <= issue_pkg::q_count_t'(`QUEUE_DEPTH - 2);
    assign push     = in_valid && in_ready;

    always_comb begin
        if (!push) begin
            push_num = '0;
        end else if (in_pair) begin
            push_num = issue_pkg::q_count_t'(2);
        end else begin
            push_num = issue_pkg::q_count_t'(1);
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    assign wr_ptr_plus1 = wr_ptr + 1'b1;
    assign rd_ptr_plus1 = rd_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_instr0;
            if (in_pair) begin
                mem[wr_ptr_plus1] <= in_instr1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + issue_pkg::q_ptr_t'(push_num);
            rd_ptr <= rd_ptr + issue_pkg::q_ptr_t'(pop_count);
            count  <= count + push_num - issue_pkg::q_count_t'(pop_count);
        end
    end

    assign head_instr = mem[rd_ptr];
    assign next_instr = mem[rd_ptr_plus1];

    assign empty        = count == '0;
    assign almost_empty = count == issue_pkg::q_count_t'(1);

endmodule

//--- verilog/inst_decode.sv
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module inst_decode (
    input  issue_pkg::instr_t       instr,
    output issue_pkg::opcode_t      op,
    output issue_pkg::reg_addr_t    rs,
    output issue_pkg::reg_addr_t    rt,
    output issue_pkg::reg_addr_t    reg_waddr,
    output logic                    reg_wen,
    output logic                    mem_en,
    output logic                    mem_to_reg,
    output logic                    is_branch,
    output logic                    is_spec_inst,
    output logic                    is_only_in_master
);

    issue_pkg::reg_addr_t rd;
    logic [5:0]           funct;

    assign op    = instr[31:26];
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];
    assign funct = instr[5:0];

    always_comb begin
        reg_wen           = 1'b0;
        reg_waddr         = rt;
        mem_en            = 1'b0;
        mem_to_reg        = 1'b0;
        is_branch         = 1'b0;
        is_spec_inst      = 1'b0;
        is_only_in_master = 1'b0;
        case (op)
            `OP_SPECIAL_INST: begin
                reg_waddr = rd;
                case (funct)
                    `FN_JR:                is_branch = 1'b1;
                    `FN_SYSCALL:           is_only_in_master = 1'b1;
                    // HI/LO writers; no GPR result.
                    `FN_MULT, `FN_DIV:     is_spec_inst = 1'b1;
                    `FN_MFHI, `FN_MFLO: begin
                        is_spec_inst = 1'b1;
                        reg_wen      = 1'b1;
                    end
                    default:               reg_wen = 1'b1;
                endcase
            end
            `OP_REGIMM, `OP_J, `OP_BEQ, `OP_BNE: is_branch = 1'b1;
            `OP_JAL: begin
                is_branch = 1'b1;
                reg_wen   = 1'b1;
                reg_waddr = 5'd31;
            end
            `OP_LW: begin
                mem_en     = 1'b1;
                mem_to_reg = 1'b1;
                reg_wen    = 1'b1;
            end
            `OP_SW:                        mem_en = 1'b1;
            `OP_ADDIU, `OP_ORI, `OP_LUI:   reg_wen = 1'b1;
            `OP_COP0: begin
                is_only_in_master = 1'b1;
                // MFC0 writes rt.
                reg_wen           = rs == 5'd0;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/issue_ctrl.sv
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module issue_ctrl (
    input  logic                    D_master_en,
    input  logic                    D_master_reg_wen,
    input  logic                    D_master_mem_en,
    input  issue_pkg::reg_addr_t    D_master_reg_waddr,
    input  logic                    D_master_is_branch,
    input  logic                    D_master_is_spec_inst,
    input  logic                    E_master_memtoReg,
    input  logic                    M_master_memtoReg,
    input  issue_pkg::reg_addr_t    E_master_reg_waddr,
    input  issue_pkg::reg_addr_t    M_master_reg_waddr,
    input  issue_pkg::opcode_t      D_slave_op,
    input  issue_pkg::reg_addr_t    D_slave_rs,
    input  issue_pkg::reg_addr_t    D_slave_rt,
    input  logic                    D_slave_mem_en,
    input  logic                    D_slave_is_branch,
    input  logic                    D_slave_is_spec_inst,
    input  logic                    D_slave_is_only_in_master,
    input  logic                    fifo_empty,
    input  logic                    fifo_almost_empty,
    output logic                    D_slave_is_in_delayslot,
    output logic                    D_slave_en
);

    logic fifo_ok;
    logic struct_ok;
    logic dep_ok;
    logic load_stall;

    // Two entries must be present for a pair.
    assign fifo_ok = !(fifo_empty || fifo_almost_empty);

    assign struct_ok = D_master_en && !D_master_mem_en && !D_master_is_branch
                     && !D_master_is_spec_inst && !D_slave_mem_en && !D_slave_is_branch
                     && !D_slave_is_spec_inst && !D_slave_is_only_in_master;

    always_comb begin
        dep_ok = 1'b1;
        if (D_master_reg_wen && (D_master_reg_waddr != 5'd0)) begin
            // Only R-type slaves read rt as a source.
            if (D_slave_op == `OP_SPECIAL_INST) begin
                dep_ok = (D_slave_rs != D_master_reg_waddr) && (D_slave_rt != D_master_reg_waddr);
            end else begin
                dep_ok = D_slave_rs != D_master_reg_waddr;
            end
        end
    end

    assign load_stall =
        (E_master_memtoReg && (D_slave_rs == E_master_reg_waddr || D_slave_rt == E_master_reg_waddr))
     || (M_master_memtoReg && (D_slave_rs == M_master_reg_waddr || D_slave_rt == M_master_reg_waddr));

    assign D_slave_en              = struct_ok && dep_ok && fifo_ok && !load_stall;
    assign D_slave_is_in_delayslot = D_master_is_branch && D_slave_en;

endmodule

//--- verilog/load_stage_track.sv
`timescale 1ns/1ps

module load_stage_track (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    d_mem_to_reg,
    input  issue_pkg::reg_addr_t    d_waddr,
    output logic                    e_mem_to_reg,
    output issue_pkg::reg_addr_t    e_waddr,
    output logic                    m_mem_to_reg,
    output issue_pkg::reg_addr_t    m_waddr
);

    // Load flags, one stage per cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_mem_to_reg <= 1'b0;
            m_mem_to_reg <= 1'b0;
        end else begin
            e_mem_to_reg <= d_mem_to_reg;
            m_mem_to_reg <= e_mem_to_reg;
        end
    end

    // Destination only matters while its flag is set.
    always_ff @(posedge clk) begin
        e_waddr <= d_waddr;
        m_waddr <= e_waddr;
    end

endmodule

//--- verilog/issue_config.sv
`timescale 1ns/1ps

module issue_config (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_we,
    input  logic                    cfg_wdata,
    input  logic                    pair_issued,
    output logic                    dual_en,
    output issue_pkg::pair_count_t  pair_count
);

    // Dual issue is on out of reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dual_en <= 1'b1;
        end else if (cfg_we) begin
            dual_en <= cfg_wdata;
        end
    end

    // Saturates at all ones.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_count <= '0;
        end else if (pair_issued && (pair_count != '1)) begin
            pair_count <= pair_count + 1'b1;
        end
    end

endmodule

//--- verilog/dual_issue_front.sv
`timescale 1ns/1ps

module dual_issue_front (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    in_pair,
    input  issue_pkg::instr_t       in_instr0,
    input  issue_pkg::instr_t       in_instr1,
    input  logic                    cfg_we,
    input  logic                    cfg_wdata,
    output logic                    in_ready,
    output logic                    issue_valid0,
    output issue_pkg::instr_t       issue_instr0,
    output logic                    issue_valid1,
    output issue_pkg::instr_t       issue_instr1,
    output logic                    slave_is_in_delayslot,
    output logic                    dual_en,
    output issue_pkg::pair_count_t  pair_count
);

    logic                   empty;
    logic                   almost_empty;
    logic [1:0]             pop_count;
    logic                   slave_ok;

    issue_pkg::reg_addr_t   m_waddr_d;
    logic                   m_reg_wen;
    logic                   m_mem_en;
    logic                   m_mem_to_reg;
    logic                   m_is_branch;
    logic                   m_is_spec;

    issue_pkg::opcode_t     s_op;
    issue_pkg::reg_addr_t   s_rs;
    issue_pkg::reg_addr_t   s_rt;
    logic                   s_mem_en;
    logic                   s_is_branch;
    logic                   s_is_spec;
    logic                   s_only_master;

    logic                   e_load;
    logic                   m_load;
    issue_pkg::reg_addr_t   e_load_waddr;
    issue_pkg::reg_addr_t   m_load_waddr;

    // The head always issues when present.
    assign issue_valid0 = !empty;
    assign issue_valid1 = slave_ok && dual_en;
    assign pop_count    = {1'b0, issue_valid0} + {1'b0, issue_valid1};

    inst_queue u_queue (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_pair(in_pair),
        .in_instr0(in_instr0), .in_instr1(in_instr1), .pop_count(pop_count),
        .head_instr(issue_instr0), .next_instr(issue_instr1),
        .empty(empty), .almost_empty(almost_empty), .in_ready(in_ready)
    );

    inst_decode master_dec (
        .instr(issue_instr0), .op(), .rs(), .rt(), .reg_waddr(m_waddr_d),
        .reg_wen(m_reg_wen), .mem_en(m_mem_en), .mem_to_reg(m_mem_to_reg),
        .is_branch(m_is_branch), .is_spec_inst(m_is_spec), .is_only_in_master()
    );

    inst_decode slave_dec (
        .instr(issue_instr1), .op(s_op), .rs(s_rs), .rt(s_rt), .reg_waddr(),
        .reg_wen(), .mem_en(s_mem_en), .mem_to_reg(),
        .is_branch(s_is_branch), .is_spec_inst(s_is_spec), .is_only_in_master(s_only_master)
    );

    issue_ctrl u_issue_ctrl (
        .D_master_en(issue_valid0), .D_master_reg_wen(m_reg_wen),
        .D_master_mem_en(m_mem_en), .D_master_reg_waddr(m_waddr_d),
        .D_master_is_branch(m_is_branch), .D_master_is_spec_inst(m_is_spec),
        .E_master_memtoReg(e_load), .M_master_memtoReg(m_load),
        .E_master_reg_waddr(e_load_waddr), .M_master_reg_waddr(m_load_waddr),
        .D_slave_op(s_op), .D_slave_rs(s_rs), .D_slave_rt(s_rt),
        .D_slave_mem_en(s_mem_en), .D_slave_is_branch(s_is_branch),
        .D_slave_is_spec_inst(s_is_spec), .D_slave_is_only_in_master(s_only_master),
        .fifo_empty(empty), .fifo_almost_empty(almost_empty),
        .D_slave_is_in_delayslot(slave_is_in_delayslot), .D_slave_en(slave_ok)
    );

    load_stage_track u_load_track (
        .clk(clk), .rst_n(rst_n), .d_mem_to_reg(m_mem_to_reg && issue_valid0),
        .d_waddr(m_waddr_d), .e_mem_to_reg(e_load), .e_waddr(e_load_waddr),
        .m_mem_to_reg(m_load), .m_waddr(m_load_waddr)
    );

    issue_config u_config (
        .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_wdata(cfg_wdata),
        .pair_issued(issue_valid1), .dual_en(dual_en), .pair_count(pair_count)
    );

endmodule

//--- bench/dual_issue_front_assertions.sv
`timescale 1ns/1ps

module dual_issue_front_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic issue_valid0,
    input logic issue_valid1,
    input logic slave_is_in_delayslot
);

    logic no_push_yet;

    // High from reset until the first push is seen.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            no_push_yet <= 1'b1;
        end else if (in_valid) begin
            no_push_yet <= 1'b0;
        end
    end

    slave_needs_master: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid1 |-> issue_valid0)
        else $error("slave slot issued without the master slot");

    delayslot_needs_slave: assert property (@(posedge clk) disable iff (!rst_n)
        slave_is_in_delayslot |-> issue_valid1)
        else $error("delay slot flag set without a slave issue");

    quiet_until_push: assert property (@(posedge clk) disable iff (!rst_n)
        no_push_yet |-> !issue_valid0)
        else $error("issue before any instruction was pushed");

endmodule

bind dual_issue_front dual_issue_front_assertions assertions0 (.*);

//--- bench/tb_dual_issue_front.sv
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module tb_dual_issue_front;

    localparam int FN_ADDU = 'h21;
    // All tests together take about 130 cycles.
    localparam int MAX_CYCLES = 400;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_pair;
    issue_pkg::instr_t      in_instr0;
    issue_pkg::instr_t      in_instr1;
    logic                   cfg_we;
    logic                   cfg_wdata;
    logic                   in_ready;
    logic                   issue_valid0;
    issue_pkg::instr_t      issue_instr0;
    logic                   issue_valid1;
    issue_pkg::instr_t      issue_instr1;
    logic                   slave_is_in_delayslot;
    logic                   dual_en;
    issue_pkg::pair_count_t pair_count;

    // Reference model state.
    issue_pkg::instr_t      mq[$];
    logic                   ex_load;
    logic                   mem_load;
    logic [4:0]             ex_dest;
    logic [4:0]             mem_dest;
    logic                   dual_en_m;
    int                     pairs_m;
    int                     mismatch_count;
    int                     other_count;
    int                     cycle_count;
    logic [15:0]            lfsr;

    dual_issue_front dut0 (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic issue_pkg::instr_t rtype(int fn, int rd, int rs, int rt);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn[5:0]};
    endfunction

    function automatic issue_pkg::instr_t itype(int op, int rt, int rs, int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic issue_pkg::instr_t random_alu();
        int rs;
        int rt;
        int rd;
        rs = int'(take_bits(5));
        rt = int'(take_bits(5));
        rd = int'(take_bits(5));
        if (take_bits(1) == 16'd1) begin
            return rtype(FN_ADDU, rd, rs, rt);
        end
        return itype(`OP_ADDIU, rt, rs, int'(take_bits(16)));
    endfunction

    // Blocks pairing as master, blocks as slave, written register (0 if none), load.
    function automatic void classify(input issue_pkg::instr_t w, output logic no_master,
                                     output logic no_slave, output logic [4:0] dest,
                                     output logic load);
        no_master = 1'b0;
        no_slave  = 1'b0;
        dest      = 5'd0;
        load      = 1'b0;
        case (w[31:26])
            `OP_SPECIAL_INST: begin
                if (w[5:0] == `FN_SYSCALL) begin
                    no_slave = 1'b1;
                end else if (w[5:0] inside {`FN_JR, `FN_MULT, `FN_DIV, `FN_MFHI, `FN_MFLO}) begin
                    no_master = 1'b1;
                end else begin
                    dest = w[15:11];
                end
            end
            `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_REGIMM, `OP_SW: no_master = 1'b1;
            `OP_LW: begin
                no_master = 1'b1;
                dest      = w[20:16];
                load      = 1'b1;
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI: dest = w[20:16];
            `OP_COP0: no_slave = 1'b1;
            default: ;
        endcase
        no_slave = no_slave || no_master;
    endfunction

    task automatic flag_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        other_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // Compares this cycle's outputs with the model, then moves the model one edge on.
    task automatic check_cycle();
        logic mst_block;
        logic mst_load;
        logic slv_block;
        logic unused_flag;
        logic [4:0] unused_dest;
        logic [4:0] mst_dest;
        logic [4:0] s_rs;
        logic [4:0] s_rt;
        logic exp_v0;
        logic exp_v1;
        logic exp_ready;
        exp_v0    = mq.size() > 0;
        exp_v1    = 1'b0;
        exp_ready = mq.size() <= `QUEUE_DEPTH - 2;
        mst_load  = 1'b0;
        mst_dest  = 5'd0;
        if (exp_v0) begin
            classify(mq[0], mst_block, unused_flag, mst_dest, mst_load);
        end
        if (mq.size() > 1 && dual_en_m) begin
            classify(mq[1], unused_flag, slv_block, unused_dest, unused_flag);
            s_rs   = mq[1][25:21];
            s_rt   = mq[1][20:16];
            exp_v1 = !mst_block && !slv_block
                && !(mst_dest != 5'd0 && (s_rs == mst_dest
                     || (mq[1][31:26] == `OP_SPECIAL_INST && s_rt == mst_dest)))
                && !(ex_load && (s_rs == ex_dest || s_rt == ex_dest))
                && !(mem_load && (s_rs == mem_dest || s_rt == mem_dest));
        end
        assert (issue_valid0 === exp_v0 && issue_valid1 === exp_v1)
            else flag_mismatch($sformatf("issue valids %b%b, expected %b%b",
                               issue_valid0, issue_valid1, exp_v0, exp_v1));
        assert (!exp_v0 || issue_instr0 === mq[0])
            else flag_mismatch($sformatf("slot 0 word %h, expected %h", issue_instr0, mq[0]));
        assert (!exp_v1 || issue_instr1 === mq[1])
            else flag_mismatch($sformatf("slot 1 word %h, expected %h", issue_instr1, mq[1]));
        assert (in_ready === exp_ready && dual_en === dual_en_m
                && int'(pair_count) == pairs_m && slave_is_in_delayslot === 1'b0)
            else flag_mismatch($sformatf(
                "ready/dual_en/pairs/delayslot %b %b %0d %b, exp %b %b %0d 0",
                in_ready, dual_en, pair_count, slave_is_in_delayslot,
                exp_ready, dual_en_m, pairs_m));
        assert (!in_valid || exp_ready)
            else note_failure("a push was driven while the queue had no room");
        mem_load = ex_load;
        mem_dest = ex_dest;
        ex_load  = exp_v0 && mst_load;
        ex_dest  = mst_dest;
        pairs_m += int'(exp_v1);
        repeat (int'(exp_v0) + int'(exp_v1)) begin
            void'(mq.pop_front());
        end
        if (cfg_we) begin
            dual_en_m = cfg_wdata;
        end
        if (in_valid && exp_ready) begin
            mq.push_back(in_instr0);
            if (in_pair) begin
                mq.push_back(in_instr1);
            end
        end
    endtask

    task automatic cycle(input logic v, input logic pair, input issue_pkg::instr_t i0,
                         input issue_pkg::instr_t i1, input logic we, input logic wd);
        @(posedge clk);
        in_valid  <= v;
        in_pair   <= pair;
        in_instr0 <= i0;
        in_instr1 <= i1;
        cfg_we    <= we;
        cfg_wdata <= wd;
        @(negedge clk);
        check_cycle();
    endtask

    task automatic idle();
        cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic push_pair(input issue_pkg::instr_t a, input issue_pkg::instr_t b);
        cycle(1'b1, 1'b1, a, b, 1'b0, 1'b0);
    endtask

    // One extra cycle lets the last pair reach the counter.
    task automatic drain();
        while (mq.size() > 0) begin
            idle();
        end
        idle();
    endtask

    task automatic check_pairs(input int start, input int n, input string what);
        assert (int'(pair_count) - start == n)
            else flag_mismatch($sformatf("%s: %0d pairs, expected %0d",
                               what, int'(pair_count) - start, n));
    endtask

    task automatic pair_case(input issue_pkg::instr_t a, input issue_pkg::instr_t b,
                             input int n, input string what);
        int start;
        start = int'(pair_count);
        push_pair(a, b);
        drain();
        check_pairs(start, n, what);
    endtask

    task automatic test_reset();
        idle();
        assert (issue_valid0 === 1'b0 && issue_valid1 === 1'b0 && in_ready === 1'b1
                && dual_en === 1'b1 && pair_count === '0)
            else flag_mismatch("outputs after reset differ from their reset values");
    endtask

    task automatic test_pairing();
        pair_case(rtype(FN_ADDU, 1, 2, 3), rtype(FN_ADDU, 4, 5, 6), 1, "independent pair");
        pair_case(rtype(FN_ADDU, 1, 2, 3), rtype(FN_ADDU, 4, 1, 5), 0, "rs reads master dest");
        pair_case(rtype(FN_ADDU, 1, 2, 3), rtype(FN_ADDU, 4, 5, 1), 0, "rt reads master dest");
        pair_case(rtype(FN_ADDU, 1, 2, 3), itype(`OP_ADDIU, 1, 5, 7), 1, "I-type rt");
        pair_case(rtype(FN_ADDU, 0, 2, 3), rtype(FN_ADDU, 4, 0, 0), 1, "master writes r0");
    endtask

    task automatic test_loads_and_classes();
        int start;
        start = int'(pair_count);
        push_pair(itype(`OP_LW, 7, 2, 0), rtype(FN_ADDU, 9, 3, 4));
        push_pair(rtype(FN_ADDU, 10, 7, 1), rtype(FN_ADDU, 11, 7, 2));
        push_pair(rtype(FN_ADDU, 12, 7, 3), rtype(FN_ADDU, 13, 5, 6));
        drain();
        check_pairs(start, 1, "slaves behind a load in E and M");
        pair_case(itype(`OP_BEQ, 1, 2, 4), rtype(FN_ADDU, 4, 5, 6), 0, "master branch");
        pair_case(itype(`OP_LW, 1, 2, 0), rtype(FN_ADDU, 4, 5, 6), 0, "master load");
        pair_case(rtype(`FN_MULT, 0, 2, 3), rtype(FN_ADDU, 4, 5, 6), 0, "master multiply");
        pair_case(rtype(FN_ADDU, 4, 5, 6), rtype(`FN_SYSCALL, 0, 0, 0), 0, "slave syscall");
    endtask

    task automatic test_single_issue();
        int start;
        cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b0);
        start = int'(pair_count);
        push_pair(rtype(FN_ADDU, 1, 2, 3), rtype(FN_ADDU, 4, 5, 6));
        push_pair(rtype(FN_ADDU, 7, 8, 9), rtype(FN_ADDU, 10, 11, 12));
        push_pair(rtype(FN_ADDU, 13, 14, 15), rtype(FN_ADDU, 16, 17, 18));
        drain();
        check_pairs(start, 0, "dual issue disabled");
        cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1);
        start = int'(pair_count);
        cycle(1'b1, 1'b0, rtype(FN_ADDU, 1, 2, 3), '0, 1'b0, 1'b0);
        drain();
        check_pairs(start, 0, "lone queue entry");
    endtask

    task automatic test_random();
        int pushed;
        issue_pkg::instr_t first;
        issue_pkg::instr_t second;
        pushed = 0;
        while (pushed < 40) begin
            if (mq.size() <= `QUEUE_DEPTH - 2) begin
                first  = random_alu();
                second = random_alu();
                push_pair(first, second);
                pushed += 2;
            end else begin
                idle();
            end
        end
        drain();
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_pair        = 1'b0;
        in_instr0      = '0;
        in_instr1      = '0;
        cfg_we         = 1'b0;
        cfg_wdata      = 1'b0;
        ex_load        = 1'b0;
        mem_load       = 1'b0;
        ex_dest        = 5'd0;
        mem_dest       = 5'd0;
        dual_en_m      = 1'b1;
        pairs_m        = 0;
        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        lfsr           = 16'd51381;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_pairing();
        test_loads_and_classes();
        test_single_issue();
        test_random();
        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- dual_issue_front.f
+incdir+include
verilog/issue_pkg.sv
verilog/inst_queue.sv
verilog/inst_decode.sv
verilog/issue_ctrl.sv
verilog/load_stage_track.sv
verilog/issue_config.sv
verilog/dual_issue_front.sv
bench/dual_issue_front_assertions.sv
bench/tb_dual_issue_front.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dual_issue_front
FILELIST  ?= dual_issue_front.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
